// ==== project.f ====
+incdir+.
pipe_pkg.sv
apb_pkg.sv
stage_if.sv
sync_fifo.sv
apb_ctrl_fsm.sv
mul_timer.sv
bypass_unit.sv
stall_unit.sv
exec_pipe.sv
hazard_core_top.sv
hazard_core_properties.sv
tb_hazard_core.sv

// ==== tb_hazard_core.sv ====
module tb_hazard_core import pipe_pkg::*;;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NumProg = 4;
	localparam int ProgStalls [NumProg] = '{0, 3, 0, 0};
	// Rows are op, rd, rs, rt; imm comes from the LFSR
	localparam logic [16:0] Fixed [19] = '{
		{MUL, 5'd0, 5'd0, 5'd0}, {MUL, 5'd0, 5'd0, 5'd0}, // Freeze so words pile up
		{ADD, 5'd1, 5'd0, 5'd0}, {ADD, 5'd2, 5'd1, 5'd1}, {SUB, 5'd3, 5'd2, 5'd1},
		{ADD, 5'd4, 5'd3, 5'd2}, {SUB, 5'd5, 5'd4, 5'd3}, {ADD, 5'd0, 5'd5, 5'd4},
		{ADD, 5'd6, 5'd0, 5'd5}, {SUB, 5'd7, 5'd6, 5'd0},
		{MUL, 5'd0, 5'd0, 5'd0}, {MUL, 5'd0, 5'd0, 5'd0},
		{LOAD, 5'd1, 5'd0, 5'd0}, {ADD, 5'd3, 5'd1, 5'd1}, // Use right after load
		{LOAD, 5'd2, 5'd0, 5'd0}, {ADD, 5'd4, 5'd3, 5'd3}, {SUB, 5'd5, 5'd2, 5'd4},
		{MUL, 5'd8, 5'd7, 5'd6}, {ADD, 5'd9, 5'd8, 5'd7}
	};

	logic pclk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	int errors;
	int checks;
	int maxWait;
	int stallsBefore;
	logic [15:0] lfsr;
	logic [31:0] regModel [32];
	logic [31:0] dmemModel [16];
	logic [31:0] progWords [$];
	logic [31:0] expTrace [$];
	logic [31:0] rdata;
	logic err;

	hazard_core_top dut_i (.*);

	initial pclk = 1'b0;
	always #20 pclk = ~pclk;

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic finishRun();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	endtask

	task automatic timedOut(input string what);
		$display("Timeout while waiting for %s at %0t", what, $time);
		errors++;
		finishRun();
	endtask

	task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic apbXfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rd, output logic er);
		int n;
		@(posedge pclk);
		psel <= 1'b1; // Setup phase
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge pclk);
		penable <= 1'b1;
		n = 0;
		@(negedge pclk);
		while (!pready) begin
			n++;
			if (n > 400)
				timedOut("pready");
			@(negedge pclk);
		end
		if (n > maxWait)
			maxWait = n;
		rd = prdata;
		er = pslverr;
	endtask

	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		logic er;
		apbXfer(1'b1, addr, wdata, unused, er);
		checkValue("pslverr on write", {31'd0, er}, 32'd0);
	endtask

	task automatic waitIdle();
		int n;
		n = 0;
		apbXfer(1'b0, 8'h04, '0, rdata, err);
		while (!(rdata[0] && !rdata[1])) begin // Queue empty and pipe drained
			n++;
			if (n > 300)
				timedOut("pipeline idle");
			apbXfer(1'b0, 8'h04, '0, rdata, err);
		end
	endtask

	task automatic runModel(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] v;
		a = regModel[w[24:20]];
		b = regModel[w[19:15]];
		case (w[31:30])
			2'd0: v = a + b + {17'd0, w[14:0]};
			2'd1: v = a - b;
			2'd2: v = a * b;
			default: v = dmemModel[4'(a + {17'd0, w[14:0]})];
		endcase
		if (w[29:25] != 5'd0) begin
			regModel[w[29:25]] = v;
			expTrace.push_back(v);
		end
	endtask

	task automatic buildProgram(input int p);
		progWords.delete();
		case (p)
			0: for (int i = 0; i < 10; i++)
				progWords.push_back({Fixed[i], 15'(randBits(15))});
			1: for (int i = 10; i < 17; i++)
				progWords.push_back({Fixed[i], 15'(randBits(15))});
			2: begin
				for (int i = 0; i < 16; i++) // Slow MULs let the queue fill
					progWords.push_back({MUL, 15'd0, 15'(randBits(15))});
				for (int i = 17; i < 19; i++)
					progWords.push_back({Fixed[i], 15'(randBits(15))});
			end
			default: for (int k = 0; k < 18; k++)
				progWords.push_back({ADD, 5'(10 + k), 5'(k % 8), 5'd0, 15'(randBits(15))});
		endcase
	endtask

	task automatic drainTrace();
		int n;
		foreach (expTrace[i]) begin
			n = 0;
			apbXfer(1'b0, 8'h0C, '0, rdata, err);
			while (err) begin
				n++;
				if (n > 300)
					timedOut("trace entry");
				apbXfer(1'b0, 8'h0C, '0, rdata, err);
			end
			checkValue("trace value", rdata, expTrace[i]);
		end
		waitIdle();
		apbXfer(1'b0, 8'h0C, '0, rdata, err);
		checkValue("pslverr on empty pop", {31'd0, err}, 32'd1);
		checkValue("prdata on empty pop", rdata, 32'd0);
	endtask

	task automatic waitTraceFull();
		int n;
		n = 0;
		apbXfer(1'b0, 8'h04, '0, rdata, err);
		while (rdata[8:4] != 5'd16) begin
			n++;
			if (n > 300)
				timedOut("full trace queue");
			apbXfer(1'b0, 8'h04, '0, rdata, err);
		end
	endtask

	initial begin
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rst = 1'b1;
		errors = 0;
		checks = 0;
		maxWait = 0;
		lfsr = 16'd9008;
		foreach (regModel[i])
			regModel[i] = '0;
		repeat (16) @(posedge pclk);
		rst <= 1'b0;
		for (int a = 0; a < 16; a++) begin
			dmemModel[a] = randBits(32);
			apbWrite(8'h40 + 8'(a * 4), dmemModel[a]);
		end
		apbXfer(1'b0, 8'h10, '0, rdata, err);
		checkValue("STALLS after reset", rdata, 32'd0);
		for (int p = 0; p < NumProg; p++) begin
			buildProgram(p);
			expTrace.delete();
			foreach (progWords[i])
				runModel(progWords[i]);
			apbXfer(1'b0, 8'h10, '0, rdata, err);
			stallsBefore = rdata;
			maxWait = 0;
			foreach (progWords[i])
				apbWrite(8'h00, progWords[i]);
			if (p == 2) begin
				checks++;
				if (maxWait == 0) begin
					errors++;
					$display("Full instruction queue never held pready low");
				end
			end
			if (p == 3) begin
				waitTraceFull();
				repeat (10) @(posedge pclk);
				apbXfer(1'b0, 8'h04, '0, rdata, err);
				checkValue("trace count while full", {27'd0, rdata[8:4]}, 32'd16);
				checkValue("busy while trace full", {31'd0, rdata[1]}, 32'd1);
			end
			drainTrace();
			apbXfer(1'b0, 8'h10, '0, rdata, err);
			checkValue("STALLS increase", rdata - stallsBefore, 32'(ProgStalls[p]));
		end
		finishRun();
	end
endmodule

// ==== hazard_core_properties.sv ====
module hazard_core_properties import pipe_pkg::*; (
	input logic pclk,
	input logic rst,
	input logic holdAll,
	input logic tracePush,
	input logic waitCond,
	input logic psel,
	input logic penable,
	input logic pready,
	input microOp idUop,
	input microOp exUop,
	input microOp mem1Uop,
	input microOp mem2Uop,
	input microOp wbUop
);
	timeunit 1ns;
	timeprecision 100ps;

	// Frozen pipe keeps every stage register
	holdAllFreezes: assert property (@(posedge pclk) disable iff (rst)
		holdAll |=> (idUop === $past(idUop)) && (exUop === $past(exUop)) &&
		(mem1Uop === $past(mem1Uop)) && (mem2Uop === $past(mem2Uop)) &&
		(wbUop === $past(wbUop)))
		else $error("stage register changed while holdAll was high");

	// A retired entry leaves WB before the next retire
	singleRetire: assert property (@(posedge pclk) disable iff (rst)
		tracePush |=> !tracePush || (wbUop !== $past(wbUop)))
		else $error("same WB entry retired twice");

	// First access cycle after a setup phase completes unless the queue is full
	readyNoWait: assert property (@(posedge pclk) disable iff (rst)
		(psel && penable && $past(psel && !penable) && !waitCond) |-> pready)
		else $error("pready low in the first access cycle without a wait condition");
endmodule

bind hazard_core_top hazard_core_properties propsI (
	.pclk(pclk), .rst(rst), .holdAll(pipeU.holdAll), .tracePush(pipeU.tracePush),
	.waitCond(apbU.waitCond), .psel(psel), .penable(penable), .pready(pready),
	.idUop(pipeU.idUop), .exUop(pipeU.exUop), .mem1Uop(pipeU.mem1Uop),
	.mem2Uop(pipeU.mem2Uop), .wbUop(pipeU.wbUop)
);

// ==== hazard_core_top.sv ====
`include "hazard_cfg.svh"

module hazard_core_top import pipe_pkg::*; (
	input  logic pclk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [7:0] paddr,
	input  logic [`DATA_W-1:0] pwdata,
	output logic [`DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	logic iqPush, iqFull, iqPop, iqEmpty;
	logic dmemWe, tracePush, tracePop, traceFull, traceEmpty;
	logic pipeBusy, frontStall;
	logic [`DATA_W-1:0] iqWord, iqHead, dmemData;
	logic [$clog2(`DMEM_WORDS)-1:0] dmemAddr;
	logic [$clog2(`TQ_DEPTH):0] traceCount;
	traceEntry traceIn, traceHead;

	apb_ctrl_fsm apbU (
		.pclk(pclk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .iqPush(iqPush), .iqWord(iqWord), .iqFull(iqFull),
		.dmemWe(dmemWe), .dmemAddr(dmemAddr), .dmemData(dmemData),
		.traceHead(traceHead), .traceEmpty(traceEmpty), .traceCount(traceCount),
		.tracePop(tracePop), .iqEmpty(iqEmpty), .pipeBusy(pipeBusy),
		.frontStall(frontStall)
	);

	sync_fifo #(.T(logic [`DATA_W-1:0]), .DEPTH(`IQ_DEPTH)) instrQ (
		.pclk(pclk), .rst(rst), .push(iqPush), .pushData(iqWord), .full(iqFull),
		.pop(iqPop), .popData(iqHead), .empty(iqEmpty), .count()
	);

	sync_fifo #(.T(traceEntry), .DEPTH(`TQ_DEPTH)) traceQ (
		.pclk(pclk), .rst(rst), .push(tracePush), .pushData(traceIn), .full(traceFull),
		.pop(tracePop), .popData(traceHead), .empty(traceEmpty), .count(traceCount)
	);

	exec_pipe pipeU (
		.pclk(pclk), .rst(rst), .iqWord(iqHead), .iqEmpty(iqEmpty), .iqPop(iqPop),
		.dmemWe(dmemWe), .dmemAddr(dmemAddr), .dmemData(dmemData),
		.traceFull(traceFull), .tracePush(tracePush), .traceData(traceIn),
		.pipeBusy(pipeBusy), .frontStall(frontStall)
	);
endmodule

// ==== exec_pipe.sv ====
`include "hazard_cfg.svh"

module exec_pipe import pipe_pkg::*; (
	input  logic pclk,
	input  logic rst,
	input  logic [`DATA_W-1:0] iqWord,
	input  logic iqEmpty,
	output logic iqPop,
	input  logic dmemWe,
	input  logic [$clog2(`DMEM_WORDS)-1:0] dmemAddr,
	input  logic [`DATA_W-1:0] dmemData,
	input  logic traceFull,
	output logic tracePush,
	output traceEntry traceData,
	output logic pipeBusy,
	output logic frontStall
);
	localparam int DmemAw = $clog2(`DMEM_WORDS);

	microOp idUop, exUop, mem1Uop, mem2Uop, wbUop;
	logic [`DATA_W-1:0] rf [2**`REG_AW];
	logic [`DATA_W-1:0] dmem [`DMEM_WORDS];
	logic [`DATA_W-1:0] idA, idB, exA, exB, opA, opB, aluOut;
	logic [`DATA_W-1:0] mem1Result, mem2Result, wbResult;
	logic [`REG_AW-1:0] idRt;
	fwdSel rsSel, rtSel;
	logic rsLate, rtLate, holdAll, holdFront, mulBusy, mulStart, wbWr;

	stage_if exIf();
	stage_if mem1If();
	stage_if mem2If();
	stage_if wbIf();

	assign exIf.rd = exUop.rd;
	assign exIf.rfWr = exUop.valid && (exUop.rd != '0);
	assign exIf.isLoad = exUop.valid && (exUop.op == LOAD);
	assign exIf.result = aluOut;
	assign mem1If.rd = mem1Uop.rd;
	assign mem1If.rfWr = mem1Uop.valid && (mem1Uop.rd != '0);
	assign mem1If.isLoad = mem1Uop.valid && (mem1Uop.op == LOAD);
	assign mem1If.result = mem1Result;
	assign mem2If.rd = mem2Uop.rd;
	assign mem2If.rfWr = mem2Uop.valid && (mem2Uop.rd != '0);
	assign mem2If.isLoad = mem2Uop.valid && (mem2Uop.op == LOAD);
	assign mem2If.result = mem2Result;
	assign wbIf.rd = wbUop.rd;
	assign wbIf.rfWr = wbWr;
	assign wbIf.isLoad = wbUop.valid && (wbUop.op == LOAD);
	assign wbIf.result = wbResult;

	assign idRt = (idUop.op == LOAD) ? '0 : idUop.rt; // LOAD has no rt operand

	stall_unit stallU (
		.idRs(idUop.rs), .idRt(idRt), .idValid(idUop.valid), .ex(exIf), .mem1(mem1If),
		.mulBusy(mulBusy), .traceFull(traceFull), .holdAll(holdAll),
		.holdFront(holdFront), .frontStall(frontStall)
	);

	bypass_unit bypassU (
		.exRs(exUop.rs), .exRt(exUop.rt), .ex2(mem1If), .mem2(mem2If), .wb(wbIf),
		.rsSel(rsSel), .rtSel(rtSel), .rsLate(rsLate), .rtLate(rtLate)
	);

	assign mulStart = !holdAll && !holdFront && idUop.valid && (idUop.op == MUL);
	mul_timer mulU (.pclk(pclk), .rst(rst), .start(mulStart), .busy(mulBusy));

	assign wbWr = wbUop.valid && (wbUop.rd != '0);
	assign iqPop = !holdAll && !holdFront && !iqEmpty;
	assign tracePush = wbWr && !holdAll; // Retire
	assign traceData = '{rd: wbUop.rd, value: wbResult};
	assign pipeBusy = idUop.valid || exUop.valid || mem1Uop.valid || mem2Uop.valid ||
		wbUop.valid;

	function automatic logic [`DATA_W-1:0] rfRead(input logic [`REG_AW-1:0] idx);
		if (idx == '0)
			return '0;
		if (wbWr && (wbUop.rd == idx))
			return wbResult; // Write-before-read
		return rf[idx];
	endfunction

	always_comb begin
		idA = rfRead(idUop.rs);
		idB = rfRead(idUop.rt);
		opA = exA;
		opB = exB;
		if (rsSel == FROM_MEM1)
			opA = mem1Result;
		else if (rsSel == FROM_MEM2_WB)
			opA = rsLate ? wbResult : mem2Result;
		if (rtSel == FROM_MEM1)
			opB = mem1Result;
		else if (rtSel == FROM_MEM2_WB)
			opB = rtLate ? wbResult : mem2Result;
		case (exUop.op)
			ADD: aluOut = opA + opB + `DATA_W'(exUop.imm);
			SUB: aluOut = opA - opB;
			MUL: aluOut = opA * opB; // Low word only
			default: aluOut = opA + `DATA_W'(exUop.imm); // Load address
		endcase
	end

	always_ff @(posedge pclk) begin
		if (rst) begin
			idUop.valid <= 1'b0;
			exUop.valid <= 1'b0;
			mem1Uop.valid <= 1'b0;
			mem2Uop.valid <= 1'b0;
			wbUop.valid <= 1'b0;
		end else if (!holdAll) begin
			if (!holdFront) begin
				if (iqEmpty)
					idUop.valid <= 1'b0;
				else
					idUop <= decodeWord(iqWord);
				exUop <= idUop;
			end else begin
				exUop.valid <= 1'b0; // Bubble
			end
			mem1Uop <= exUop;
			mem2Uop <= mem1Uop;
			wbUop <= mem2Uop;
		end
	end

	always_ff @(posedge pclk) begin
		if (!holdAll) begin
			if (!holdFront) begin
				exA <= idA;
				exB <= idB;
			end
			mem1Result <= aluOut;
			// Data memory read during MEM1
			mem2Result <= (mem1Uop.op == LOAD) ? dmem[mem1Result[DmemAw-1:0]] : mem1Result;
			wbResult <= mem2Result;
		end
		if (dmemWe)
			dmem[dmemAddr] <= dmemData;
	end

	always_ff @(posedge pclk) begin
		if (rst) begin
			for (int i = 0; i < 2**`REG_AW; i++)
				rf[i] <= '0;
		end else if (tracePush) begin
			rf[wbUop.rd] <= wbResult;
		end
	end
endmodule

// ==== stall_unit.sv ====
`include "hazard_cfg.svh"

module stall_unit (
	input  logic [`REG_AW-1:0] idRs,
	input  logic [`REG_AW-1:0] idRt,
	input  logic idValid,
	stage_if.mon ex,
	stage_if.mon mem1,
	input  logic mulBusy,
	input  logic traceFull,
	output logic holdAll,
	output logic holdFront,
	output logic frontStall
);
	logic exUse;
	logic mem1Use;

	// Load data exists only from MEM2 on
	assign exUse = ex.isLoad && ex.rfWr && ((ex.rd == idRs) || (ex.rd == idRt));
	assign mem1Use = mem1.isLoad && mem1.rfWr && ((mem1.rd == idRs) || (mem1.rd == idRt));

	assign holdAll = mulBusy || traceFull;      // Whole pipe frozen
	assign holdFront = idValid && (exUse || mem1Use); // ID and queue held, bubble to EX

	// Counted only when the back of the pipe moves
	assign frontStall = holdFront && !holdAll;
endmodule

// ==== bypass_unit.sv ====
`include "hazard_cfg.svh"

module bypass_unit import pipe_pkg::*; (
	input  logic [`REG_AW-1:0] exRs,
	input  logic [`REG_AW-1:0] exRt,
	stage_if.mon ex2,
	stage_if.mon mem2,
	stage_if.mon wb,
	output fwdSel rsSel,
	output fwdSel rtSel,
	output logic rsLate,
	output logic rtLate
);
	// Youngest matching writer wins
	function automatic fwdSel pickSrc(input logic [`REG_AW-1:0] src, output logic late);
		late = 1'b0;
		if (ex2.rfWr && (ex2.rd == src))
			return FROM_MEM1;
		if (mem2.rfWr && (mem2.rd == src))
			return FROM_MEM2_WB;
		late = 1'b1; // Only WB left
		if (wb.rfWr && (wb.rd == src))
			return FROM_MEM2_WB;
		late = 1'b0;
		return NONE; // Register file value from ID
	endfunction

	always_comb begin
		rsSel = pickSrc(exRs, rsLate);
		rtSel = pickSrc(exRt, rtLate);
	end
endmodule

// ==== mul_timer.sv ====
`include "hazard_cfg.svh"

module mul_timer (
	input  logic pclk,
	input  logic rst,
	input  logic start,
	output logic busy
);
	localparam int CntW = $clog2(`MUL_CYCLES + 1);

	logic [CntW-1:0] count;

	// Loaded as the multiply enters EX
	always_ff @(posedge pclk) begin
		if (rst)
			count <= '0;
		else if (start)
			count <= CntW'(`MUL_CYCLES);
		else if (count != '0)
			count <= count - 1'b1;
	end

	assign busy = (count != '0); // Drops in the last EX cycle
endmodule

// ==== apb_ctrl_fsm.sv ====
`include "hazard_cfg.svh"

module apb_ctrl_fsm import pipe_pkg::*, apb_pkg::*; (
	input  logic pclk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [7:0] paddr,
	input  logic [`DATA_W-1:0] pwdata,
	output logic [`DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic iqPush,
	output logic [`DATA_W-1:0] iqWord,
	input  logic iqFull,
	output logic dmemWe,
	output logic [$clog2(`DMEM_WORDS)-1:0] dmemAddr,
	output logic [`DATA_W-1:0] dmemData,
	input  traceEntry traceHead,
	input  logic traceEmpty,
	input  logic [$clog2(`TQ_DEPTH):0] traceCount,
	output logic tracePop,
	input  logic iqEmpty,
	input  logic pipeBusy,
	input  logic frontStall
);
	apbState state;
	apbState nextState;
	logic [`DATA_W-1:0] stallCount;
	logic inDmem;
	logic waitCond;
	logic xfer;

	assign inDmem = ((paddr & 8'hC3) == DMEM_BASE); // 0x40..0x7C word aligned
	assign waitCond = pwrite && (paddr == IQ_PUSH) && iqFull;
	assign pready = (state == ACCESS) && !waitCond;
	assign xfer = pready && psel && penable;

	assign iqPush = xfer && pwrite && (paddr == IQ_PUSH);
	assign iqWord = pwdata;
	assign dmemWe = xfer && pwrite && inDmem;
	assign dmemAddr = paddr[2 +: $clog2(`DMEM_WORDS)];
	assign dmemData = pwdata;
	assign tracePop = xfer && !pwrite && (paddr == TRACE_POP) && !traceEmpty;

	always_comb begin
		nextState = state;
		case (state)
			IDLE: if (psel && !penable) nextState = ACCESS; // Setup phase seen
			ACCESS: nextState = waitCond ? WAIT : IDLE;
			WAIT: if (!waitCond) nextState = ACCESS;    // Queue has room again
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge pclk) begin
		if (rst)
			state <= IDLE;
		else
			state <= nextState;
	end

	always_comb begin
		prdata = '0;
		pslverr = 1'b0;
		if (pready) begin
			if (pwrite) begin
				pslverr = !((paddr == IQ_PUSH) || inDmem);
			end else begin
				case (paddr)
					STATUS: begin
						prdata[0] = iqEmpty;
						prdata[1] = pipeBusy;
						prdata[4 +: $bits(traceCount)] = traceCount;
					end
					TRACE_RD: if (!traceEmpty) prdata = traceHead.value;
					TRACE_POP: begin
						if (traceEmpty)
							pslverr = 1'b1;
						else
							prdata = traceHead.value;
					end
					STALLS: prdata = stallCount;
					default: pslverr = 1'b1; // Unmapped read
				endcase
			end
		end
	end

	always_ff @(posedge pclk) begin
		if (rst)
			stallCount <= '0;
		else if (frontStall)
			stallCount <= stallCount + 1'b1;
	end
endmodule

// ==== sync_fifo.sv ====
module sync_fifo #(
	parameter type T = logic [31:0],
	parameter int DEPTH = 8
) (
	input  logic pclk,
	input  logic rst,
	input  logic push,
	input  T pushData,
	output logic full,
	input  logic pop,
	output T popData,
	output logic empty,
	output logic [$clog2(DEPTH):0] count
);
	localparam int PtrW = $clog2(DEPTH);

	T mem [DEPTH];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic doPush;
	logic doPop;

	assign doPush = push && !full;
	assign doPop = pop && !empty;
	assign full = (count == DEPTH);
	assign empty = (count == '0);
	assign popData = mem[rdPtr]; // Head valid while not empty

	always_ff @(posedge pclk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= (wrPtr == PtrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PtrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge pclk) begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end
endmodule

// ==== stage_if.sv ====
`include "hazard_cfg.svh"

// Destination info of one pipeline stage
interface stage_if;
	logic [`REG_AW-1:0] rd;
	logic rfWr; // Never set with rd of zero
	logic isLoad;
	logic [`DATA_W-1:0] result;

	modport src (
		output rd,
		output rfWr,
		output isLoad,
		output result
	);

	modport mon (
		input rd,
		input rfWr,
		input isLoad,
		input result
	);
endinterface

// ==== apb_pkg.sv ====
package apb_pkg;

	typedef enum logic [7:0] {
		IQ_PUSH   = 8'h00, // Write only
		STATUS    = 8'h04,
		TRACE_RD  = 8'h08, // Peek at trace head
		TRACE_POP = 8'h0C,
		STALLS    = 8'h10,
		DMEM_BASE = 8'h40  // Window up to 0x7C
	} apbReg;

	typedef enum logic [1:0] {IDLE, ACCESS, WAIT} apbState;

endpackage

// ==== pipe_pkg.sv ====
`include "hazard_cfg.svh"

package pipe_pkg;

	typedef enum logic [1:0] {ADD, SUB, MUL, LOAD} opType;

	typedef struct packed {
		opType op;
		logic [`REG_AW-1:0] rd;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [14:0] imm; // Zero-extended in EX
		logic valid;
	} microOp;

	// FROM_MEM2_WB is split by a separate late flag
	typedef enum logic [1:0] {NONE, FROM_EX, FROM_MEM1, FROM_MEM2_WB} fwdSel;

	typedef struct packed {
		logic [`REG_AW-1:0] rd;
		logic [`DATA_W-1:0] value;
	} traceEntry;

	function automatic microOp decodeWord(input logic [`DATA_W-1:0] w);
		microOp u;
		u.op = opType'(w[31:30]);
		u.rd = w[29:25];
		u.rs = w[24:20];
		u.rt = w[19:15];
		u.imm = w[14:0];
		u.valid = 1'b1;
		return u;
	endfunction

endpackage

// ==== hazard_cfg.svh ====
`ifndef HAZARD_CFG_SVH
`define HAZARD_CFG_SVH

// Datapath and register file
`define DATA_W 32
`define REG_AW 5

// Queue depths
`define IQ_DEPTH 8
`define TQ_DEPTH 16

// Extra EX cycles for a multiply
`define MUL_CYCLES 4

`define DMEM_WORDS 16

`endif
